//--- hdl/ecdsa_defs.svh
`ifndef ECDSA_DEFS_SVH
`define ECDSA_DEFS_SVH

`default_nettype none

// Number of parallel inverse lanes, 1 to 8
`define INV_LANES 4

// Data words after a VERIFY_SIG header
// s (4), r (4), hash (4), Q (8)
`define SIG_WORDS 20

// Command code of a signature verification packet
`define CMD_VERIFY_SIG 8'h01

`default_nettype wire

`endif

//--- hdl/ecdsa_pkg.sv
`default_nettype none

package ecdsa_pkg;

  // secp256k1 group order n
  localparam logic [255:0] ECDSA_N =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_BAAEDCE6_AF48A03B_BFD25E8C_D0364141;

  // Header word at the start of every packet
  typedef struct packed {
    logic [7:0]  cmd;
    logic [7:0]  tag;
    logic [15:0] len;
    logic [31:0] reserved;
  } cmd_hdr_t;

  // One stream word, read as header or as raw data
  typedef union packed {
    cmd_hdr_t    hdr;
    logic [63:0] dat;
  } cmd_word_u;

  // Command stream beat
  typedef struct packed {
    cmd_word_u word;
    logic      val;
    logic      eop;
  } cmd_beat_t;

  // Job handed to an inverse lane
  typedef struct packed {
    logic [7:0]   tag;
    logic [255:0] s;
    logic         bad_s;
    logic         bad_r;
  } inv_job_t;

  // Result of one lane, w = s^-1 mod n
  typedef struct packed {
    logic [7:0]   tag;
    logic [255:0] w;
    logic         bad_s;
    logic         bad_r;
  } inv_res_t;

endpackage

`default_nettype wire

//--- hdl/sig_cmd_parser.sv
`timescale 1ns/1ps
`include "ecdsa_defs.svh"
`default_nettype none

module sig_cmd_parser import ecdsa_pkg::*; (
  input  wire       i_clk,
  input  wire       i_rst,
  input  cmd_beat_t i_cmd,
  output logic      o_cmd_rdy,
  output inv_job_t  o_job,
  output logic      o_job_val,
  input  wire       i_job_rdy
);

  localparam int LAST_WORD = `SIG_WORDS - 1;
  localparam int CNT_W     = $clog2(`SIG_WORDS);
  // Word index where r starts and where the hash starts
  localparam int R_FIRST   = 4;
  localparam int H_FIRST   = 8;

  typedef enum logic [1:0] {IDLE, PARSE, ISSUE, IGNORE} parse_state_t;

  parse_state_t     state;
  logic [CNT_W-1:0] cnt;
  logic             run_q;
  cmd_word_u        word;
  logic             cmd_fire;
  logic             hdr_slot;
  logic             is_verify;
  logic [255:0]     r_q;
  inv_job_t         job_q;

  assign word = i_cmd.word;

  // Input opens one cycle after reset
  // and closes only while a job waits for a free lane
  assign o_cmd_rdy = run_q && ((state != ISSUE) || i_job_rdy);
  assign cmd_fire  = i_cmd.val && o_cmd_rdy;

  // A header can arrive in IDLE or in the cycle the job is taken
  assign hdr_slot  = (state == IDLE) || (state == ISSUE);
  assign is_verify = (word.hdr.cmd == `CMD_VERIFY_SIG);

  assign o_job     = job_q;
  assign o_job_val = (state == ISSUE);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
      cnt   <= '0;
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      case (state)
        IDLE, ISSUE: begin
          if (state == ISSUE && i_job_rdy)
            state <= IDLE;
          if (cmd_fire) begin
            cnt <= '0;
            if (is_verify)
              state <= PARSE;
            else if (!i_cmd.eop)
              state <= IGNORE;
          end
        end
        PARSE: begin
          if (cmd_fire) begin
            cnt <= cnt + 1'b1;
            if (cnt == LAST_WORD)
              state <= ISSUE;
          end
        end
        IGNORE: begin
          // Drop everything up to the end of the packet
          if (cmd_fire && i_cmd.eop)
            state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Payload capture, words are little-endian within each value
  always_ff @(posedge i_clk) begin
    if (cmd_fire && hdr_slot && is_verify)
      job_q.tag <= word.hdr.tag;
    if (cmd_fire && state == PARSE) begin
      if (cnt < R_FIRST)
        job_q.s[cnt[1:0]*64 +: 64] <= word.dat;
      else if (cnt < H_FIRST)
        r_q[cnt[1:0]*64 +: 64] <= word.dat;
      // hash and Q words are discarded
      if (cnt == LAST_WORD) begin
        job_q.bad_s <= (job_q.s == '0) || (job_q.s >= ECDSA_N);
        job_q.bad_r <= (r_q == '0) || (r_q >= ECDSA_N);
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/inv_lane_dispatch.sv
`timescale 1ns/1ps
`include "ecdsa_defs.svh"
`default_nettype none

module inv_lane_dispatch import ecdsa_pkg::*; (
  input  inv_job_t              i_job,
  input  wire                   i_job_val,
  output logic                  o_job_rdy,
  input  wire [`INV_LANES-1:0]  i_lane_busy,
  output logic [`INV_LANES-1:0] o_lane_start,
  output inv_job_t              o_lane_job
);

  logic [`INV_LANES-1:0] free;
  logic [`INV_LANES-1:0] first_free;

  assign free = ~i_lane_busy;

  // Isolate the lowest set bit, so lane 0 wins ties
  assign first_free = free & (~free + 1'b1);

  // Ready as soon as any lane can take the job
  assign o_job_rdy = |free;

  // Start pulse only on the job handshake
  assign o_lane_start = i_job_val ? first_free : '0;

  // All lanes see the same job bus, start selects the taker
  assign o_lane_job = i_job;

endmodule

`default_nettype wire

//--- hdl/bin_inv_mod.sv
`timescale 1ns/1ps
`default_nettype none

module bin_inv_mod import ecdsa_pkg::*; (
  input  wire      i_clk,
  input  wire      i_rst,
  input  wire      i_start,
  input  inv_job_t i_job,
  output logic     o_busy,
  output inv_res_t o_res,
  output logic     o_done,
  input  wire      i_ack
);

  typedef enum logic [1:0] {IDLE, RUN, DONE} lane_state_t;

  lane_state_t  state;
  logic [255:0] u, v, x1, x2;
  inv_res_t     res_q;

  // x / 2 mod n, add n first when x is odd
  function automatic logic [255:0] mod_half(input logic [255:0] a);
    logic [256:0] t;
    t = a[0] ? ({1'b0, a} + {1'b0, ECDSA_N}) : {1'b0, a};
    return t[256:1];
  endfunction

  // a - b mod n, both operands below n
  function automatic logic [255:0] mod_sub(input logic [255:0] a, input logic [255:0] b);
    logic [255:0] d;
    d = a - b;
    if (a < b)
      d = d + ECDSA_N;
    return d;
  endfunction

  assign o_busy = (state != IDLE);
  assign o_done = (state == DONE);
  assign o_res  = res_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
    end else begin
      case (state)
        // bad s skips the iteration and reports w = 0
        IDLE: if (i_start) state <= i_job.bad_s ? DONE : RUN;
        RUN:  if (u == 256'd1 || v == 256'd1) state <= DONE;
        DONE: if (i_ack) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  // Invariants u = x1*s and v = x2*s mod n
  always_ff @(posedge i_clk) begin
    if (state == IDLE && i_start) begin
      res_q.tag   <= i_job.tag;
      res_q.bad_s <= i_job.bad_s;
      res_q.bad_r <= i_job.bad_r;
      res_q.w     <= '0;
      u           <= i_job.s;
      v           <= ECDSA_N;
      x1          <= 256'd1;
      x2          <= '0;
    end else if (state == RUN) begin
      if (u == 256'd1) begin
        res_q.w <= x1;
      end else if (v == 256'd1) begin
        res_q.w <= x2;
      end else if (!u[0]) begin
        u  <= u >> 1;
        x1 <= mod_half(x1);
      end else if (!v[0]) begin
        v  <= v >> 1;
        x2 <= mod_half(x2);
      end else if (u >= v) begin
        // Both odd, the difference is even so halve it in the same step
        u  <= (u - v) >> 1;
        x1 <= mod_half(mod_sub(x1, x2));
      end else begin
        v  <= (v - u) >> 1;
        x2 <= mod_half(mod_sub(x2, x1));
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/inv_result_collect.sv
`timescale 1ns/1ps
`include "ecdsa_defs.svh"
`default_nettype none

module inv_result_collect import ecdsa_pkg::*; (
  input  wire                         i_clk,
  input  wire                         i_rst,
  input  inv_res_t [`INV_LANES-1:0]   i_lane_res,
  input  wire [`INV_LANES-1:0]        i_lane_done,
  output logic [`INV_LANES-1:0]       o_lane_ack,
  output inv_res_t                    o_res,
  output logic                        o_res_val,
  input  wire                         i_res_rdy
);

  localparam int LANES = `INV_LANES;
  localparam int IDX_W = (LANES > 1) ? $clog2(LANES) : 1;

  logic [IDX_W-1:0] pick_idx;
  logic             load_en;
  logic             take;

  // Lowest numbered done lane has priority
  always_comb begin
    pick_idx = '0;
    for (int i = LANES - 1; i >= 0; i--) begin
      if (i_lane_done[i])
        pick_idx = IDX_W'(i);
    end
  end

  // Output register is free or drains this cycle
  assign load_en    = !o_res_val || i_res_rdy;
  assign take       = load_en && (|i_lane_done);
  assign o_lane_ack = take ? (LANES'(1) << pick_idx) : '0;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_res_val <= 1'b0;
    end else if (take) begin
      o_res_val <= 1'b1;
    end else if (i_res_rdy) begin
      o_res_val <= 1'b0;
    end
  end

  // Holds while stalled
  always_ff @(posedge i_clk) begin
    if (take)
      o_res <= i_lane_res[pick_idx];
  end

endmodule

`default_nettype wire

//--- hdl/ecdsa_verify_front.sv
`timescale 1ns/1ps
`include "ecdsa_defs.svh"
`default_nettype none

module ecdsa_verify_front import ecdsa_pkg::*; (
  input  wire       i_clk,
  input  wire       i_rst,
  input  cmd_beat_t i_cmd,
  output logic      o_cmd_rdy,
  output inv_res_t  o_res,
  output logic      o_res_val,
  input  wire       i_res_rdy
);

  inv_job_t                  job;
  logic                      job_val;
  logic                      job_rdy;
  inv_job_t                  lane_job;
  logic [`INV_LANES-1:0]     lane_start;
  logic [`INV_LANES-1:0]     lane_busy;
  logic [`INV_LANES-1:0]     lane_done;
  logic [`INV_LANES-1:0]     lane_ack;
  inv_res_t [`INV_LANES-1:0] lane_res;

  sig_cmd_parser u_parser (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_cmd     (i_cmd),
    .o_cmd_rdy (o_cmd_rdy),
    .o_job     (job),
    .o_job_val (job_val),
    .i_job_rdy (job_rdy)
  );

  inv_lane_dispatch u_dispatch (
    .i_job        (job),
    .i_job_val    (job_val),
    .o_job_rdy    (job_rdy),
    .i_lane_busy  (lane_busy),
    .o_lane_start (lane_start),
    .o_lane_job   (lane_job)
  );

  // Parallel inverse lanes
  for (genvar i = 0; i < `INV_LANES; i++) begin : g_lane
    bin_inv_mod u_inv (
      .i_clk   (i_clk),
      .i_rst   (i_rst),
      .i_start (lane_start[i]),
      .i_job   (lane_job),
      .o_busy  (lane_busy[i]),
      .o_res   (lane_res[i]),
      .o_done  (lane_done[i]),
      .i_ack   (lane_ack[i])
    );
  end

  inv_result_collect u_collect (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_lane_res  (lane_res),
    .i_lane_done (lane_done),
    .o_lane_ack  (lane_ack),
    .o_res       (o_res),
    .o_res_val   (o_res_val),
    .i_res_rdy   (i_res_rdy)
  );

endmodule

`default_nettype wire

//--- verification/ecdsa_verify_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module ecdsa_verify_assertions import ecdsa_pkg::*; (
  input wire           i_clk,
  input wire           i_rst,
  input wire inv_res_t o_res,
  input wire           o_res_val,
  input wire           i_res_rdy
);

  // Number of failed assertions
  int fail_cnt = 0;

  // A stalled result keeps its value until it is taken
  property p_hold_on_stall;
    @(posedge i_clk) disable iff (i_rst)
      (o_res_val && !i_res_rdy) |=> (o_res_val && $stable(o_res));
  endproperty

  a_hold_on_stall: assert property (p_hold_on_stall)
    else begin
      $error("o_res changed or dropped while stalled");
      fail_cnt++;
    end

  // Output valid is cleared by reset
  a_reset_val: assert property (@(posedge i_clk) (i_rst ##1 i_rst) |-> !o_res_val)
    else begin
      $error("o_res_val high during reset");
      fail_cnt++;
    end

  a_bad_s_w: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_res_val && o_res.bad_s) |-> (o_res.w == '0))
    else begin
      $error("w not zero for a result with bad_s");
      fail_cnt++;
    end

endmodule

`default_nettype wire

//--- verification/ecdsa_verify_tb.sv
`timescale 1ns/1ps
`include "ecdsa_defs.svh"
`default_nettype none

module ecdsa_verify_tb import ecdsa_pkg::*; ();

  localparam int TIMEOUT = 2000;

  logic      i_clk;
  logic      i_rst;
  cmd_beat_t i_cmd;
  logic      o_cmd_rdy;
  inv_res_t  o_res;
  logic      o_res_val;
  logic      i_res_rdy;

  logic [31:0]  rng;
  logic [31:0]  bp_rng;
  logic         bp_on;
  logic         timed_out;
  int           errors;
  int           err_mark;
  int           n_results;
  int           n_pending;
  // Scoreboard indexed by tag
  logic [255:0] sb_s [256];
  logic [255:0] sb_r [256];
  logic         pending [256];
  logic [7:0]   rtag;
  logic [2:0]   chk;
  inv_res_t     prev_res;
  logic         prev_stall;

  ecdsa_verify_front dut0 (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_cmd     (i_cmd),
    .o_cmd_rdy (o_cmd_rdy),
    .o_res     (o_res),
    .o_res_val (o_res_val),
    .i_res_rdy (i_res_rdy)
  );

  bind ecdsa_verify_front ecdsa_verify_assertions chk0 (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .o_res     (o_res),
    .o_res_val (o_res_val),
    .i_res_rdy (i_res_rdy)
  );

  always #20 i_clk = ~i_clk;

  function automatic logic [31:0] lcg_step(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [255:0] rand256();
    logic [255:0] v;
    for (int i = 0; i < 8; i++) begin
      rng = lcg_step(rng);
      v[i*32 +: 32] = rng;
    end
    return v;
  endfunction

  function automatic logic [255:0] rand_below_n();
    logic [255:0] v;
    v = rand256();
    while (v == '0 || v >= ECDSA_N)
      v = rand256();
    return v;
  endfunction

  // Returns {w_ok, bad_s, bad_r}
  function automatic logic [2:0] expected_result(input logic [255:0] s, input logic [255:0] r,
                                                 input logic [255:0] w);
    logic         bs;
    logic         br;
    logic [511:0] p;
    bs = (s == '0) || (s >= ECDSA_N);
    br = (r == '0) || (r >= ECDSA_N);
    p  = {256'b0, s} * {256'b0, w};
    p  = p % {256'b0, ECDSA_N};
    return {(bs ? (w == '0) : (p == 512'd1)), bs, br};
  endfunction

  task automatic report_timeout(input string what);
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
    errors++;
    timed_out = 1'b1;
  endtask

  // Called on a falling edge and returns on the falling edge after the transfer
  task automatic send_beat(input logic [63:0] d, input logic eop);
    int t;
    t = 0;
    if (timed_out)
      return;
    i_cmd.word.dat = d;
    i_cmd.val      = 1'b1;
    i_cmd.eop      = eop;
    while (!o_cmd_rdy && t < TIMEOUT) begin
      @(negedge i_clk);
      t++;
    end
    if (!o_cmd_rdy) begin
      report_timeout("the command input to become ready");
    end else begin
      @(negedge i_clk);
    end
    i_cmd.val = 1'b0;
    i_cmd.eop = 1'b0;
  endtask

  task automatic send_sig(input logic [7:0] tag, input logic [255:0] s, input logic [255:0] r);
    logic [255:0] h;
    logic [511:0] q;
    h = rand256();
    q = {rand256(), rand256()};
    sb_s[tag]    = s;
    sb_r[tag]    = r;
    pending[tag] = 1'b1;
    n_pending++;
    send_beat({`CMD_VERIFY_SIG, tag, 16'(`SIG_WORDS), 32'h0}, 1'b0);
    for (int i = 0; i < 4; i++)
      send_beat(s[i*64 +: 64], 1'b0);
    for (int i = 0; i < 4; i++)
      send_beat(r[i*64 +: 64], 1'b0);
    for (int i = 0; i < 4; i++)
      send_beat(h[i*64 +: 64], 1'b0);
    for (int i = 0; i < 8; i++)
      send_beat(q[i*64 +: 64], i == 7);
  endtask

  // Unknown command code with a random payload length
  task automatic send_ignored(input logic [7:0] tag);
    logic [7:0] cmd;
    int         len;
    rng = lcg_step(rng);
    cmd = rng[23:16];
    if (cmd == `CMD_VERIFY_SIG)
      cmd = 8'h7f;
    len = 1 + rng[29:27];
    send_beat({cmd, tag, 16'(len), 32'h0}, 1'b0);
    for (int i = 0; i < len; i++) begin
      rng = lcg_step(rng);
      send_beat({rng, ~rng}, i == len - 1);
    end
  endtask

  task automatic wait_idle();
    int t;
    t = 0;
    while (n_pending != 0 && t < TIMEOUT && !timed_out) begin
      @(negedge i_clk);
      t++;
    end
    if (n_pending != 0 && !timed_out)
      report_timeout("all outstanding results");
  endtask

  task automatic test_done(input string name);
    $display("test %s: %0d errors", name, errors - err_mark);
    err_mark = errors;
  endtask

  // Random back-pressure on the result port
  always @(negedge i_clk) begin
    if (bp_on) begin
      bp_rng    = lcg_step(bp_rng);
      i_res_rdy = bp_rng[31];
    end else begin
      i_res_rdy = 1'b1;
    end
  end

  // Compare each result as it is taken
  always @(posedge i_clk) begin
    if (!i_rst && o_res_val && i_res_rdy) begin
      rtag = o_res.tag;
      n_results++;
      if (!pending[rtag]) begin
        $display("Result with tag %h was not expected or arrived twice", rtag);
        errors++;
      end else begin
        chk = expected_result(sb_s[rtag], sb_r[rtag], o_res.w);
        if (o_res.bad_s !== chk[1]) begin
          $display("** Error: tag %h o_res.bad_s = %h, expected %h", rtag, o_res.bad_s, chk[1]);
          errors++;
        end
        if (o_res.bad_r !== chk[0]) begin
          $display("** Error: tag %h o_res.bad_r = %h, expected %h", rtag, o_res.bad_r, chk[0]);
          errors++;
        end
        if (!chk[2]) begin
          if (chk[1])
            $display("** Error: tag %h o_res.w = %h, expected 0", rtag, o_res.w);
          else
            $display("** Error: tag %h o_res.w = %h is no inverse of s = %h",
                     rtag, o_res.w, sb_s[rtag]);
          errors++;
        end
        pending[rtag] = 1'b0;
        n_pending--;
      end
    end
    if (!i_rst && prev_stall && (!o_res_val || o_res !== prev_res)) begin
      $display("** Error: o_res = %h changed while stalled, was %h", o_res, prev_res);
      errors++;
    end
    prev_stall = !i_rst && o_res_val && !i_res_rdy;
    prev_res   = o_res;
  end

  initial begin
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_cmd      = '0;
    i_res_rdy  = 1'b1;
    bp_on      = 1'b0;
    timed_out  = 1'b0;
    rng        = 32'd70;
    bp_rng     = 32'd70;
    errors     = 0;
    err_mark   = 0;
    n_results  = 0;
    n_pending  = 0;
    prev_stall = 1'b0;
    prev_res   = '0;
    for (int i = 0; i < 256; i++)
      pending[i] = 1'b0;
    repeat (16) @(negedge i_clk);
    i_rst = 1'b0;
    @(negedge i_clk);

    send_sig(8'h11, rand_below_n(), rand_below_n());
    wait_idle();
    test_done("single valid signature");

    send_sig(8'h20, '0, rand_below_n());
    send_sig(8'h21, ECDSA_N, rand_below_n());
    send_sig(8'h22, rand_below_n(), ECDSA_N + 256'd5);
    wait_idle();
    test_done("range errors");

    send_ignored(8'hee);
    send_sig(8'h31, rand_below_n(), rand_below_n());
    wait_idle();
    test_done("ignored command");

    for (int i = 0; i < `INV_LANES + 2; i++)
      send_sig(8'h40 + 8'(i), rand_below_n(), rand_below_n());
    wait_idle();
    test_done("parallel lanes");

    bp_on = 1'b1;
    for (int i = 0; i < `INV_LANES + 2; i++)
      send_sig(8'h50 + 8'(i), rand_below_n(), rand_below_n());
    wait_idle();
    bp_on = 1'b0;
    test_done("back-pressure");

    // Failed assertions in the bound checker count as errors too
    errors += dut0.chk0.fail_cnt;
    $display("results %0d, errors %0d", n_results, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/ecdsa_pkg.sv
hdl/sig_cmd_parser.sv
hdl/inv_lane_dispatch.sv
hdl/bin_inv_mod.sv
hdl/inv_result_collect.sv
hdl/ecdsa_verify_front.sv
verification/ecdsa_verify_assertions.sv
verification/ecdsa_verify_tb.sv
